// ==== adv_timer_pkg.sv ====
/*
 * Advanced timer APB register map
 * Address layout, field widths, register offsets and field positions
 */
package adv_timer_pkg;

	////////////////////////////////////////
	// Bus and block geometry
	////////////////////////////////////////
	localparam int APB_ADDR_WIDTH = 12;
	localparam int APB_DATA_WIDTH = 32;
	localparam int N_TIMERS       = 4;
	localparam int N_CHANNELS     = 4;
	localparam int N_EVENTS       = 4;
	localparam int TIM_IDX_W      = $clog2(N_TIMERS);

	localparam int REG_OFF_W      = 4;
	localparam int BLK_W          = 4;
	localparam int ADDR_OFF_LSB   = 2;                        // Word aligned
	localparam int ADDR_BLK_LSB   = ADDR_OFF_LSB + REG_OFF_W;
	localparam int GLOBAL_BLOCK   = 4;

	localparam int CMD_W          = 5;

	typedef logic [APB_DATA_WIDTH-1:0] apb_data_t;
	typedef logic [BLK_W-1:0]          block_idx_t;

	////////////////////////////////////////
	// Register offsets inside a block
	////////////////////////////////////////
	typedef enum logic [REG_OFF_W-1:0] {
		TIM_CMD     = 4'd0,
		TIM_CFG     = 4'd1,
		TIM_TH      = 4'd2,
		TIM_CH0_TH  = 4'd3,
		TIM_CH1_TH  = 4'd4,
		TIM_CH2_TH  = 4'd5,
		TIM_CH3_TH  = 4'd6,
		TIM_CH0_LUT = 4'd7,
		TIM_CH1_LUT = 4'd8,
		TIM_CH2_LUT = 4'd9,
		TIM_CH3_LUT = 4'd10,
		TIM_COUNTER = 4'd11
	} tim_reg_e;

	typedef enum logic [REG_OFF_W-1:0] {
		GLB_EVENT_CFG = 4'd0,
		GLB_CH_EN     = 4'd1
	} glb_reg_e;

	// Bit positions inside the CMD word
	typedef enum logic [2:0] {
		CMD_START  = 3'd0,
		CMD_STOP   = 3'd1,
		CMD_UPDATE = 3'd2,
		CMD_RST    = 3'd3,
		CMD_ARM    = 3'd4
	} tim_cmd_e;

	////////////////////////////////////////
	// Field types and positions
	////////////////////////////////////////
	typedef logic [15:0] counter_t;
	typedef logic [15:0] ch_th_t;
	typedef logic [15:0] ch_lut_t;
	typedef logic [2:0]  ch_mode_t;
	typedef logic [1:0]  ch_flt_t;
	typedef logic [7:0]  in_sel_t;
	typedef logic [7:0]  presc_t;
	typedef logic [2:0]  in_mode_t;
	typedef logic [3:0]  evt_sel_t;

	localparam int CFG_IN_SEL_LSB  = 0;
	localparam int CFG_IN_MODE_LSB = 8;
	localparam int CFG_IN_CLK_BIT  = 11;
	localparam int CFG_SAW_BIT     = 12;
	localparam int CFG_PRESC_LSB   = 16;

	localparam int CH_TH_LSB       = 0;
	localparam int CH_MODE_LSB     = 16;
	localparam int CH_LUT_LSB      = 0;
	localparam int CH_FLT_LSB      = 16;

	localparam int EVT_SEL_LSB     = 0;                       // Select n at 4n
	localparam int EVT_EN_LSB      = 16;
	localparam int CH_EN_LSB       = 0;

endpackage

// ==== adv_timer_apb_ctrl.sv ====
/*
 * Advanced timer APB control
 * Qualifies writes, decodes the block index and steers read data
 */
`timescale 1ns/1ps

module adv_timer_apb_ctrl (
	input  logic [adv_timer_pkg::APB_ADDR_WIDTH-1:0] PADDR_i,
	input  adv_timer_pkg::apb_data_t                PWDATA_i,
	input  logic                                    PWRITE_i,
	input  logic                                    PSEL_i,
	input  logic                                    PENABLE_i,
	input  adv_timer_pkg::apb_data_t                tim_rdata_i [adv_timer_pkg::N_TIMERS],
	input  adv_timer_pkg::apb_data_t                glb_rdata_i,
	output logic [adv_timer_pkg::N_TIMERS-1:0]      tim_wr_o,
	output logic                                    glb_wr_o,
	output logic [adv_timer_pkg::REG_OFF_W-1:0]     reg_off_o,
	output adv_timer_pkg::apb_data_t                wdata_o,
	output adv_timer_pkg::apb_data_t                PRDATA_o
);

	import adv_timer_pkg::*;

	logic       wr_en;
	block_idx_t blk;

	// Write commits in the access phase
	assign wr_en = PSEL_i & PENABLE_i & PWRITE_i;

	assign blk       = PADDR_i[ADDR_BLK_LSB +: BLK_W];
	assign reg_off_o = PADDR_i[ADDR_OFF_LSB +: REG_OFF_W];
	assign wdata_o   = PWDATA_i;

	////////////////////////////////////////
	// Write strobes
	////////////////////////////////////////
	always_comb
	begin
		for (int t = 0; t < N_TIMERS; t++)
		begin
			tim_wr_o[t] = wr_en && (blk == block_idx_t'(t));
		end
	end

	assign glb_wr_o = wr_en && (blk == block_idx_t'(GLOBAL_BLOCK));

	////////////////////////////////////////
	// Read data steering
	////////////////////////////////////////
	always_comb
	begin
		if (blk < block_idx_t'(N_TIMERS))
			PRDATA_o = tim_rdata_i[blk[TIM_IDX_W-1:0]];
		else if (blk == block_idx_t'(GLOBAL_BLOCK))
			PRDATA_o = glb_rdata_i;
		else
			PRDATA_o = '0;                      // Pre-divider and above
	end

endmodule

// ==== adv_timer_cfg_regs.sv ====
/*
 * Advanced timer register bank
 * Configuration and channel registers of one timer, command pulses and readback
 */
`timescale 1ns/1ps

module adv_timer_cfg_regs (
	input  logic                                HCLK,
	input  logic                                HRESETn,
	input  logic                                wr_i,
	input  logic [adv_timer_pkg::REG_OFF_W-1:0] reg_off_i,
	input  adv_timer_pkg::apb_data_t            wdata_i,
	input  adv_timer_pkg::counter_t             counter_i,
	output adv_timer_pkg::apb_data_t            rdata_o,
	output logic                                start_o,
	output logic                                stop_o,
	output logic                                update_o,
	output logic                                rst_o,
	output logic                                arm_o,
	output logic                                saw_o,
	output adv_timer_pkg::in_mode_t             in_mode_o,
	output adv_timer_pkg::in_sel_t              in_sel_o,
	output logic                                in_clk_o,
	output adv_timer_pkg::presc_t               presc_o,
	output logic [15:0]                         th_hi_o,
	output logic [15:0]                         th_low_o,
	output adv_timer_pkg::ch_mode_t             ch_mode_o [adv_timer_pkg::N_CHANNELS],
	output adv_timer_pkg::ch_flt_t              ch_flt_o [adv_timer_pkg::N_CHANNELS],
	output adv_timer_pkg::ch_th_t               ch_th_o [adv_timer_pkg::N_CHANNELS],
	output adv_timer_pkg::ch_lut_t              ch_lut_o [adv_timer_pkg::N_CHANNELS]
);

	import adv_timer_pkg::*;

	tim_reg_e         reg_off;
	logic [CMD_W-1:0] cmd_q;
	apb_data_t        th_q;
	in_sel_t          in_sel_q;
	in_mode_t         in_mode_q;
	logic             in_clk_q;
	logic             saw_q;
	presc_t           presc_q;
	ch_th_t           ch_th_q [N_CHANNELS];
	ch_mode_t         ch_mode_q [N_CHANNELS];
	ch_lut_t          ch_lut_q [N_CHANNELS];
	ch_flt_t          ch_flt_q [N_CHANNELS];

	assign reg_off = tim_reg_e'(reg_off_i);

	////////////////////////////////////////
	// Command pulses
	////////////////////////////////////////
	// High only in the cycle after a CMD write
	always_ff @(posedge HCLK, negedge HRESETn)
	begin
		if (!HRESETn)
			cmd_q <= '0;
		else if (wr_i && (reg_off == TIM_CMD))
			cmd_q <= wdata_i[CMD_W-1:0];
		else
			cmd_q <= '0;
	end

	////////////////////////////////////////
	// Configuration registers
	////////////////////////////////////////
	always_ff @(posedge HCLK, negedge HRESETn)
	begin
		if (!HRESETn)
		begin
			th_q      <= '0;
			in_sel_q  <= '0;
			in_mode_q <= '0;
			in_clk_q  <= 1'b0;
			saw_q     <= 1'b1;                  // Sawtooth by default
			presc_q   <= '0;
			for (int c = 0; c < N_CHANNELS; c++)
			begin
				ch_th_q[c]   <= '0;
				ch_mode_q[c] <= '0;
				ch_lut_q[c]  <= '0;
				ch_flt_q[c]  <= '0;
			end
		end
		else if (wr_i)
		begin
			case (reg_off)
				TIM_TH:
					th_q <= wdata_i;
				TIM_CFG:
				begin
					in_sel_q  <= wdata_i[CFG_IN_SEL_LSB +: $bits(in_sel_t)];
					in_mode_q <= wdata_i[CFG_IN_MODE_LSB +: $bits(in_mode_t)];
					in_clk_q  <= wdata_i[CFG_IN_CLK_BIT];
					saw_q     <= wdata_i[CFG_SAW_BIT];
					presc_q   <= wdata_i[CFG_PRESC_LSB +: $bits(presc_t)];
				end
				default: ;                      // CMD, COUNTER and holes
			endcase
			for (int c = 0; c < N_CHANNELS; c++)
			begin
				if (reg_off_i == REG_OFF_W'(TIM_CH0_TH + c))
				begin
					ch_th_q[c]   <= wdata_i[CH_TH_LSB +: $bits(ch_th_t)];
					ch_mode_q[c] <= wdata_i[CH_MODE_LSB +: $bits(ch_mode_t)];
				end
				if (reg_off_i == REG_OFF_W'(TIM_CH0_LUT + c))
				begin
					ch_lut_q[c] <= wdata_i[CH_LUT_LSB +: $bits(ch_lut_t)];
					ch_flt_q[c] <= wdata_i[CH_FLT_LSB +: $bits(ch_flt_t)];
				end
			end
		end
	end

	////////////////////////////////////////
	// Readback
	////////////////////////////////////////
	always_comb
	begin
		rdata_o = '0;
		case (reg_off)
			TIM_TH:
				rdata_o = th_q;
			TIM_CFG:
			begin
				rdata_o[CFG_IN_SEL_LSB +: $bits(in_sel_t)]   = in_sel_q;
				rdata_o[CFG_IN_MODE_LSB +: $bits(in_mode_t)] = in_mode_q;
				rdata_o[CFG_IN_CLK_BIT]                      = in_clk_q;
				rdata_o[CFG_SAW_BIT]                         = saw_q;
				rdata_o[CFG_PRESC_LSB +: $bits(presc_t)]     = presc_q;
			end
			TIM_COUNTER:
				rdata_o = apb_data_t'(counter_i);   // Live count, zero extended
			default: ;
		endcase
		for (int c = 0; c < N_CHANNELS; c++)
		begin
			if (reg_off_i == REG_OFF_W'(TIM_CH0_TH + c))
			begin
				rdata_o[CH_TH_LSB +: $bits(ch_th_t)]     = ch_th_q[c];
				rdata_o[CH_MODE_LSB +: $bits(ch_mode_t)] = ch_mode_q[c];
			end
			if (reg_off_i == REG_OFF_W'(TIM_CH0_LUT + c))
			begin
				rdata_o[CH_LUT_LSB +: $bits(ch_lut_t)] = ch_lut_q[c];
				rdata_o[CH_FLT_LSB +: $bits(ch_flt_t)] = ch_flt_q[c];
			end
		end
	end

	assign start_o  = cmd_q[CMD_START];
	assign stop_o   = cmd_q[CMD_STOP];
	assign update_o = cmd_q[CMD_UPDATE];
	assign rst_o    = cmd_q[CMD_RST];
	assign arm_o    = cmd_q[CMD_ARM];

	assign saw_o     = saw_q;
	assign in_mode_o = in_mode_q;
	assign in_sel_o  = in_sel_q;
	assign in_clk_o  = in_clk_q;
	assign presc_o   = presc_q;
	assign th_hi_o   = th_q[31:16];
	assign th_low_o  = th_q[15:0];

	assign ch_mode_o = ch_mode_q;
	assign ch_flt_o  = ch_flt_q;
	assign ch_th_o   = ch_th_q;
	assign ch_lut_o  = ch_lut_q;

endmodule

// ==== adv_timer_global_regs.sv ====
/*
 * Advanced timer global registers
 * Event select and enable plus per-timer clock enables
 */
`timescale 1ns/1ps

module adv_timer_global_regs (
	input  logic                                HCLK,
	input  logic                                HRESETn,
	input  logic                                wr_i,
	input  logic [adv_timer_pkg::REG_OFF_W-1:0] reg_off_i,
	input  adv_timer_pkg::apb_data_t            wdata_i,
	output logic [adv_timer_pkg::N_EVENTS-1:0]  events_en_o,
	output adv_timer_pkg::evt_sel_t             events_sel_o [adv_timer_pkg::N_EVENTS],
	output logic [adv_timer_pkg::N_TIMERS-1:0]  clk_en_o,
	output adv_timer_pkg::apb_data_t            rdata_o
);

	import adv_timer_pkg::*;

	localparam int SEL_W = $bits(evt_sel_t);

	glb_reg_e              reg_off;
	evt_sel_t              evt_sel_q [N_EVENTS];
	logic [N_EVENTS-1:0]   evt_en_q;
	logic [N_TIMERS-1:0]   clk_en_q;

	assign reg_off = glb_reg_e'(reg_off_i);

	always_ff @(posedge HCLK, negedge HRESETn)
	begin
		if (!HRESETn)
		begin
			evt_en_q <= '0;
			clk_en_q <= '0;
			for (int e = 0; e < N_EVENTS; e++)
				evt_sel_q[e] <= '0;
		end
		else if (wr_i)
		begin
			case (reg_off)
				GLB_EVENT_CFG:
				begin
					for (int e = 0; e < N_EVENTS; e++)
						evt_sel_q[e] <= wdata_i[EVT_SEL_LSB + e*SEL_W +: SEL_W];
					evt_en_q <= wdata_i[EVT_EN_LSB +: N_EVENTS];
				end
				GLB_CH_EN:
					clk_en_q <= wdata_i[CH_EN_LSB +: N_TIMERS];
				default: ;
			endcase
		end
	end

	always_comb
	begin
		rdata_o = '0;
		case (reg_off)
			GLB_EVENT_CFG:
			begin
				for (int e = 0; e < N_EVENTS; e++)
					rdata_o[EVT_SEL_LSB + e*SEL_W +: SEL_W] = evt_sel_q[e];
				rdata_o[EVT_EN_LSB +: N_EVENTS] = evt_en_q;
			end
			GLB_CH_EN:
				rdata_o[CH_EN_LSB +: N_TIMERS] = clk_en_q;
			default: ;
		endcase
	end

	assign events_en_o  = evt_en_q;
	assign events_sel_o = evt_sel_q;
	assign clk_en_o     = clk_en_q;

endmodule

// ==== adv_timer_apb_if.sv ====
/*
 * Advanced timer APB front end
 * Address decode, four timer register banks and the global bank
 */
`timescale 1ns/1ps

module adv_timer_apb_if (
	input  logic                                     HCLK,
	input  logic                                     HRESETn,
	input  logic [adv_timer_pkg::APB_ADDR_WIDTH-1:0] PADDR_i,
	input  adv_timer_pkg::apb_data_t                 PWDATA_i,
	input  logic                                     PWRITE_i,
	input  logic                                     PSEL_i,
	input  logic                                     PENABLE_i,
	output adv_timer_pkg::apb_data_t                 PRDATA_o,

	input  adv_timer_pkg::counter_t  timer_counter_i [adv_timer_pkg::N_TIMERS],

	output logic [adv_timer_pkg::N_TIMERS-1:0] timer_start_o,
	output logic [adv_timer_pkg::N_TIMERS-1:0] timer_stop_o,
	output logic [adv_timer_pkg::N_TIMERS-1:0] timer_update_o,
	output logic [adv_timer_pkg::N_TIMERS-1:0] timer_rst_o,
	output logic [adv_timer_pkg::N_TIMERS-1:0] timer_arm_o,
	output logic [adv_timer_pkg::N_TIMERS-1:0] timer_saw_o,
	output adv_timer_pkg::in_mode_t  timer_in_mode_o [adv_timer_pkg::N_TIMERS],
	output adv_timer_pkg::in_sel_t   timer_in_sel_o [adv_timer_pkg::N_TIMERS],
	output logic [adv_timer_pkg::N_TIMERS-1:0] timer_in_clk_o,
	output adv_timer_pkg::presc_t    timer_presc_o [adv_timer_pkg::N_TIMERS],
	output logic [15:0]              timer_th_hi_o [adv_timer_pkg::N_TIMERS],
	output logic [15:0]              timer_th_low_o [adv_timer_pkg::N_TIMERS],
	output adv_timer_pkg::ch_mode_t  timer_ch_mode_o
		[adv_timer_pkg::N_TIMERS][adv_timer_pkg::N_CHANNELS],
	output adv_timer_pkg::ch_flt_t   timer_ch_flt_o
		[adv_timer_pkg::N_TIMERS][adv_timer_pkg::N_CHANNELS],
	output adv_timer_pkg::ch_th_t    timer_ch_th_o
		[adv_timer_pkg::N_TIMERS][adv_timer_pkg::N_CHANNELS],
	output adv_timer_pkg::ch_lut_t   timer_ch_lut_o
		[adv_timer_pkg::N_TIMERS][adv_timer_pkg::N_CHANNELS],

	output logic [adv_timer_pkg::N_EVENTS-1:0] events_en_o,
	output adv_timer_pkg::evt_sel_t  events_sel_o [adv_timer_pkg::N_EVENTS],
	output logic [adv_timer_pkg::N_TIMERS-1:0] clk_en_o
);

	import adv_timer_pkg::*;

	logic [N_TIMERS-1:0]  tim_wr;
	logic                 glb_wr;
	logic [REG_OFF_W-1:0] reg_off;
	apb_data_t            wdata;
	apb_data_t            tim_rdata [N_TIMERS];
	apb_data_t            glb_rdata;

	adv_timer_apb_ctrl u_ctrl (
		.PADDR_i     (PADDR_i),
		.PWDATA_i    (PWDATA_i),
		.PWRITE_i    (PWRITE_i),
		.PSEL_i      (PSEL_i),
		.PENABLE_i   (PENABLE_i),
		.tim_rdata_i (tim_rdata),
		.glb_rdata_i (glb_rdata),
		.tim_wr_o    (tim_wr),
		.glb_wr_o    (glb_wr),
		.reg_off_o   (reg_off),
		.wdata_o     (wdata),
		.PRDATA_o    (PRDATA_o)
	);

	////////////////////////////////////////
	// Per-timer banks
	////////////////////////////////////////
	for (genvar t = 0; t < N_TIMERS; t++)
	begin : g_timer
		adv_timer_cfg_regs u_regs (
			.HCLK      (HCLK),
			.HRESETn   (HRESETn),
			.wr_i      (tim_wr[t]),
			.reg_off_i (reg_off),
			.wdata_i   (wdata),
			.counter_i (timer_counter_i[t]),
			.rdata_o   (tim_rdata[t]),
			.start_o   (timer_start_o[t]),
			.stop_o    (timer_stop_o[t]),
			.update_o  (timer_update_o[t]),
			.rst_o     (timer_rst_o[t]),
			.arm_o     (timer_arm_o[t]),
			.saw_o     (timer_saw_o[t]),
			.in_mode_o (timer_in_mode_o[t]),
			.in_sel_o  (timer_in_sel_o[t]),
			.in_clk_o  (timer_in_clk_o[t]),
			.presc_o   (timer_presc_o[t]),
			.th_hi_o   (timer_th_hi_o[t]),
			.th_low_o  (timer_th_low_o[t]),
			.ch_mode_o (timer_ch_mode_o[t]),
			.ch_flt_o  (timer_ch_flt_o[t]),
			.ch_th_o   (timer_ch_th_o[t]),
			.ch_lut_o  (timer_ch_lut_o[t])
		);
	end

	adv_timer_global_regs u_global (
		.HCLK         (HCLK),
		.HRESETn      (HRESETn),
		.wr_i         (glb_wr),
		.reg_off_i    (reg_off),
		.wdata_i      (wdata),
		.events_en_o  (events_en_o),
		.events_sel_o (events_sel_o),
		.clk_en_o     (clk_en_o),
		.rdata_o      (glb_rdata)
	);

endmodule

// ==== adv_timer_properties.sv ====
/*
 * Advanced timer register checks
 * Command pulse length, write strobe decode and reset state
 */
`timescale 1ns/1ps

module adv_timer_properties (
	input logic                                                    HCLK,
	input logic                                                    HRESETn,
	input logic [adv_timer_pkg::N_TIMERS*adv_timer_pkg::CMD_W-1:0] cmd_i,
	input logic [adv_timer_pkg::N_TIMERS:0]                        strb_i
);

	// A pulse drops one cycle after it rises
	a_pulse_single: assert property (@(posedge HCLK) disable iff (!HRESETn)
		(cmd_i != '0) |=> ((cmd_i & $past(cmd_i)) == '0))
		else $error("command pulse held for two cycles");

	a_strobe_onehot: assert property (@(posedge HCLK) $onehot0(strb_i))
		else $error("more than one write strobe active");

	a_reset_cmd: assert property (@(posedge HCLK) !HRESETn |-> (cmd_i == '0))
		else $error("command active during reset");

	a_release_cmd: assert property (@(posedge HCLK) $rose(HRESETn) |-> (cmd_i == '0))
		else $error("command active at reset release");

endmodule

// Pulses of all four banks and the strobes of the control module
bind adv_timer_apb_if adv_timer_properties u_props (
	.HCLK    (HCLK),
	.HRESETn (HRESETn),
	.cmd_i   ({timer_arm_o, timer_rst_o, timer_update_o, timer_stop_o, timer_start_o}),
	.strb_i  ({glb_wr, tim_wr})
);

// ==== tb_adv_timer.sv ====
/*
 * Advanced timer APB front end testbench
 * Replays the case file as APB transfers, counter drives and output checks
 */
`timescale 1ns/1ps

module tb_adv_timer;

	import adv_timer_pkg::*;

	localparam int WAIT_LIMIT = 64;

	logic                      HCLK;
	logic                      HRESETn;
	logic [APB_ADDR_WIDTH-1:0] paddr;
	apb_data_t                 pwdata;
	logic                      pwrite;
	logic                      psel;
	logic                      penable;
	apb_data_t                 prdata;
	counter_t                  counter [N_TIMERS];

	logic [N_TIMERS-1:0] start, stop, update, rst, arm, saw, in_clk;
	in_mode_t            in_mode [N_TIMERS];
	in_sel_t             in_sel [N_TIMERS];
	presc_t              presc [N_TIMERS];
	logic [15:0]         th_hi [N_TIMERS];
	logic [15:0]         th_low [N_TIMERS];
	ch_mode_t            ch_mode [N_TIMERS][N_CHANNELS];
	ch_flt_t             ch_flt [N_TIMERS][N_CHANNELS];
	ch_th_t              ch_th [N_TIMERS][N_CHANNELS];
	ch_lut_t             ch_lut [N_TIMERS][N_CHANNELS];
	logic [N_EVENTS-1:0] events_en;
	evt_sel_t            events_sel [N_EVENTS];
	logic [N_TIMERS-1:0] clk_en;

	int          errors;
	logic [15:0] lfsr_q;

	adv_timer_apb_if dut0 (
		.HCLK (HCLK), .HRESETn (HRESETn),
		.PADDR_i (paddr), .PWDATA_i (pwdata), .PWRITE_i (pwrite),
		.PSEL_i (psel), .PENABLE_i (penable), .PRDATA_o (prdata),
		.timer_counter_i (counter),
		.timer_start_o (start), .timer_stop_o (stop), .timer_update_o (update),
		.timer_rst_o (rst), .timer_arm_o (arm), .timer_saw_o (saw),
		.timer_in_mode_o (in_mode), .timer_in_sel_o (in_sel),
		.timer_in_clk_o (in_clk), .timer_presc_o (presc),
		.timer_th_hi_o (th_hi), .timer_th_low_o (th_low),
		.timer_ch_mode_o (ch_mode), .timer_ch_flt_o (ch_flt),
		.timer_ch_th_o (ch_th), .timer_ch_lut_o (ch_lut),
		.events_en_o (events_en), .events_sel_o (events_sel), .clk_en_o (clk_en)
	);

	initial
	begin
		HCLK = 1'b0;
		forever #10 HCLK = ~HCLK;
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////
	// x^16 + x^15 + x^13 + x^4 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[14] ^ s[12] ^ s[3]};
	endfunction

	task automatic random_word(output apb_data_t w);
		for (int i = 0; i < APB_DATA_WIDTH; i++)
		begin
			w[i]   = lfsr_q[15];
			lfsr_q = lfsr_next(lfsr_q);
		end
	endtask

	// Defined bits of the register at a byte address
	function automatic apb_data_t field_mask(input logic [APB_ADDR_WIDTH-1:0] a);
		logic [3:0] blk;
		logic [3:0] off;
		blk = a[9:6];
		off = a[5:2];
		if (blk < 4)
		begin
			if (off == 0) return 32'h0000_001F;
			if (off == 1) return 32'h00FF_1FFF;
			if (off >= 3 && off <= 6) return 32'h0007_FFFF;
			if (off >= 7 && off <= 10) return 32'h0003_FFFF;
		end
		else if (blk == 4)
		begin
			if (off == 0) return 32'h000F_FFFF;
			if (off == 1) return 32'h0000_000F;
		end
		return 32'hFFFF_FFFF;
	endfunction

	task automatic wait_edges(input int n);
		int k;
		k = 0;
		if (n > WAIT_LIMIT)
		begin
			$display("Timeout: a wait of %0d cycles exceeds the limit", n);
			$display("Simulation failed");
			$finish;
		end
		else
		begin
			while (k < n && k < WAIT_LIMIT)
			begin
				@(posedge HCLK);
				k++;
			end
		end
	endtask

	task automatic apb_write(input logic [APB_ADDR_WIDTH-1:0] a, input apb_data_t d);
		apb_data_t fill;
		random_word(fill);
		wait_edges(1);
		#2;
		paddr  = a;
		pwdata = (d & field_mask(a)) | (fill & ~field_mask(a));
		pwrite = 1'b1;
		psel   = 1'b1;
		wait_edges(1);
		#2 penable = 1'b1;
		wait_edges(1);
		#2;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_read(input logic [APB_ADDR_WIDTH-1:0] a, output apb_data_t d);
		wait_edges(1);
		#2;
		paddr  = a;
		pwrite = 1'b0;
		psel   = 1'b1;
		wait_edges(1);
		#2 penable = 1'b1;
		#8 d = prdata;                          // Middle of the access cycle
		wait_edges(1);
		#2;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic check_word(input logic [255:0] name, input apb_data_t exp,
		input apb_data_t act);
		if (exp !== act)
		begin
			$display("MISMATCH %0s expected %08h actual %08h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_cmd(input logic [255:0] name, input logic [CMD_W-1:0] exp,
		input logic [CMD_W-1:0] act);
		if (exp !== act)
		begin
			$display("MISMATCH %0s expected %02h actual %02h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_field(input logic [255:0] name, input logic [15:0] exp,
		input logic [15:0] act);
		if (exp !== act)
		begin
			$display("MISMATCH %0s expected %04h actual %04h", name, exp, act);
			errors++;
		end
	endtask

	function automatic logic [CMD_W-1:0] cmd_bits(input int t);
		return {arm[t], rst[t], update[t], stop[t], start[t]};
	endfunction

	// Upper nibble picks the field, lower nibble the channel or event
	function automatic logic [15:0] field_value(input int t, input logic [7:0] sel);
		int i;
		i = int'(sel[1:0]);
		case (sel[7:4])
			4'h0: case (sel[3:0])
				4'h0: return th_low[t];
				4'h1: return th_hi[t];
				4'h2: return 16'(in_sel[t]);
				4'h3: return 16'(in_mode[t]);
				4'h4: return 16'(presc[t]);
				4'h5: return 16'(in_clk[t]);
				default: return 16'(saw[t]);
			endcase
			4'h1: return ch_th[t][i];
			4'h2: return ch_lut[t][i];
			4'h3: return 16'(ch_mode[t][i]);
			4'h4: return 16'(ch_flt[t][i]);
			4'h5: return 16'(events_en);
			4'h6: return 16'(events_sel[i]);
			default: return 16'(clk_en);
		endcase
	endfunction

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////
	initial
	begin
		int            fd;
		int            r;
		int            k;
		logic [7:0]    op;
		logic [255:0]  name;
		logic [1023:0] line;
		logic [31:0]   a, b, c;
		apb_data_t     rd;

		HRESETn = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		pwrite  = 1'b0;
		psel    = 1'b0;
		penable = 1'b0;
		for (int t = 0; t < N_TIMERS; t++)
			counter[t] = '0;
		errors = 0;
		lfsr_q = 16'd7;

		k = 0;
		while (k < 8)
		begin
			@(posedge HCLK);
			k++;
		end
		#2 HRESETn = 1'b1;

		fd = $fopen("adv_timer_cases.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open the case file");
			errors++;
		end
		else
		begin
			while (!$feof(fd))
			begin
				r = $fscanf(fd, "%s", op);
				if (r != 1)
					break;
				if (op == "#")
				begin
					r = $fgets(line, fd);
					continue;
				end
				r = $fscanf(fd, "%s", name);
				if (op == "O")
					r = $fscanf(fd, "%h %h %h", a, b, c);
				else
					r = $fscanf(fd, "%h %h", a, b);
				if (op == "W")
					apb_write(a[APB_ADDR_WIDTH-1:0], b);
				else if (op == "R")
				begin
					apb_read(a[APB_ADDR_WIDTH-1:0], rd);
					check_word(name, b, rd);
				end
				else if (op == "K")
					counter[a[1:0]] = b[15:0];
				else if (op == "C")
				begin
					for (int t = 0; t < N_TIMERS; t++)
						check_cmd(name, (t == int'(a[1:0])) ? b[CMD_W-1:0] : '0, cmd_bits(t));
					wait_edges(1);
					#2;
					for (int t = 0; t < N_TIMERS; t++)
						check_cmd(name, '0, cmd_bits(t));  // Pulse is gone
				end
				else if (op == "O")
					check_field(name, c[15:0], field_value(int'(a[1:0]), b[7:0]));
				else
				begin
					$display("Unknown operation in the case file");
					errors++;
				end
			end
			$fclose(fd);
		end

		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== adv_timer_cases.txt ====
# op name then hex fields: W addr data | R addr expected | K timer count
# C timer cmd_bits | O timer field_sel expected (sel 0x = cfg/th, 1c..4c channel, 5x-7x global)
R rst_cfg0 004 00001000
R rst_cfg3 0c4 00001000
R rst_ch0th 00c 00000000
R rst_ch3lut 028 00000000
R rst_evt 100 00000000
R rst_chen 104 00000000
W wr_th1 048 12345678
R rd_th1 048 12345678
O th_low1 1 00 5678
O th_hi1 1 01 1234
W wr_cfg1 044 00AB0D25
R rd_cfg1 044 00AB0D25
O in_sel1 1 02 0025
O in_mode1 1 03 0005
O presc1 1 04 00AB
O in_clk1 1 05 0001
O saw1 1 06 0000
W wr_ch2th2 094 0005BEEF
R rd_ch2th2 094 0005BEEF
O ch_th2 2 12 BEEF
O ch_mode2 2 32 0005
W wr_ch3lut3 0e8 0002CAFE
R rd_ch3lut3 0e8 0002CAFE
O ch_lut3 3 23 CAFE
O ch_flt3 3 43 0002
W wr_evt 100 000A4321
R rd_evt 100 000A4321
O evt_en 0 50 000A
O evt_sel2 2 62 0003
W wr_chen 104 00000009
R rd_chen 104 00000009
O clk_en 0 70 0009
W cmd0 000 00000015
C pulse0 0 15
W cmd2 080 0000000A
W cfg2_after_cmd 084 00001000
C no_extend2 2 00
W cmd3 0c0 0000001F
C pulse3 3 1F
K cnt1 1 BEEF
R rd_cnt1 06c 0000BEEF
K cnt3 3 0042
R rd_cnt3 0ec 00000042
W wr_prediv0 140 FFFFFFFF
W wr_prediv3 14c FFFFFFFF
R rd_prediv0 140 00000000
R rd_prediv3 14c 00000000
W wr_counter1 06c 12345678
R rd_counter1 06c 0000BEEF
W wr_hole1 07c FFFFFFFF
R rd_hole1 07c 00000000
R keep_th1 048 12345678
R keep_cfg1 044 00AB0D25
R iso_th0 008 00000000
R iso_th3 0c8 00000000
R iso_cfg0 004 00001000
R iso_ch2th1 054 00000000

// ==== project.f ====
adv_timer_pkg.sv
adv_timer_apb_ctrl.sv
adv_timer_cfg_regs.sv
adv_timer_global_regs.sv
adv_timer_apb_if.sv
adv_timer_properties.sv
tb_adv_timer.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the APB register front end testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module tb_adv_timer -o sim_adv_timer
./obj_dir/sim_adv_timer | tee sim.log

if grep -q "Simulation failed" sim.log; then
	exit 1
fi
exit 0
